// ==== uart_cfg_pkg.sv ====
package uart_cfg_pkg;

	// 8N1 serial framing, sampled on a 16x oversampling tick
	localparam int OVERSAMPLE = 16;	// ticks per bit
	localparam int DATA_BITS  = 8;	// data bits per frame, lsb first
	localparam int HALF_BIT   = OVERSAMPLE / 2;	// start edge to mid-bit

	// the lane counters below are sized from these
	localparam int TICK_CNT_W = $clog2(OVERSAMPLE);
	localparam int BIT_CNT_W  = $clog2(DATA_BITS);

endpackage : uart_cfg_pkg

// ==== uart_types_pkg.sv ====
package uart_types_pkg;

	// frame decoder states of one receive lane
	typedef enum logic [1:0] {
		LANE_IDLE  = 2'd0,	// waiting for a falling edge
		LANE_START = 2'd1,	// checking the start bit at mid-bit
		LANE_DATA  = 2'd2,	// shifting in data bits
		LANE_STOP  = 2'd3	// waiting for the stop sample
	} lane_state_e;

	// one received byte
	typedef logic [7:0] rx_byte_t;

endpackage : uart_types_pkg

// ==== rx_lane_if.sv ====
`timescale 1ns/100ps

interface rx_lane_if
	import uart_types_pkg::*;
();

	logic     line;	// synchronized serial level
	logic     start;	// falling edge seen on line
	logic     done;	// frame complete, one cycle
	rx_byte_t data;	// valid with done
	logic     frame_err;	// stop bit was low, valid with done

	// synchronizer and edge detect side
	modport front (
		output line,
		output start
	);

	// frame decoder
	modport lane (
		input  line,
		input  start,
		output done,
		output data,
		output frame_err
	);

	// collector side
	modport sink (
		input done,
		input data,
		input frame_err
	);

endinterface : rx_lane_if

// ==== rx_front.sv ====
`timescale 1ns/100ps

module rx_front
	import uart_cfg_pkg::*;
#(
	parameter int CLK_FREQ  = 50_000_000,
	parameter int BAUD      = 115_200,
	parameter int NUM_LANES = 4
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] rx,
	output logic                 tick,
	rx_lane_if.front             lanes [NUM_LANES]
);

	// clocks per oversampling tick
	localparam int TICK_DIV = CLK_FREQ / (BAUD * OVERSAMPLE);
	localparam int DIV_W    = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;

	logic [DIV_W-1:0] div_cnt;

	// free-running divider, one tick per wrap
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			div_cnt <= '0;
			tick    <= 1'b0;
		end else begin
			if (div_cnt == DIV_W'(TICK_DIV - 1))
				div_cnt <= '0;
			else
				div_cnt <= div_cnt + 1'b1;
			tick <= (div_cnt == DIV_W'(TICK_DIV - 1));
		end
	end

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_sync
		logic [1:0] sync;	// two-flop synchronizer
		logic       line_d;	// previous synchronized level

		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n) begin
				sync           <= 2'b11;	// line idles high
				line_d         <= 1'b1;
				lanes[g].start <= 1'b0;
			end else begin
				sync           <= {sync[0], rx[g]};
				line_d         <= sync[1];
				lanes[g].start <= line_d & ~sync[1];	// high to low
			end
		end

		assign lanes[g].line = sync[1];

		// an edge pulse follows a high level and then a low one
		a_start_after_high: assert property (
			@(posedge clk) disable iff (!rst_n)
			lanes[g].start |-> (!$past(lanes[g].line) && $past(lanes[g].line, 2))
		) else $error("start pulse on lane %0d without a falling edge", g);
	end

endmodule : rx_front

// ==== rx_lane.sv ====
`timescale 1ns/100ps

module rx_lane
	import uart_cfg_pkg::*;
	import uart_types_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    tick,
	rx_lane_if.lane bus
);

	lane_state_e           state;
	logic [TICK_CNT_W-1:0] tick_cnt;	// ticks within the current bit
	logic [BIT_CNT_W-1:0]  bit_cnt;	// data bit index
	rx_byte_t              shreg;	// data shift register

	logic half_end;	// mid-point of the start bit
	logic bit_end;	// mid-point of a data or stop bit

	assign half_end = tick && (tick_cnt == TICK_CNT_W'(HALF_BIT - 1));
	assign bit_end  = tick && (tick_cnt == TICK_CNT_W'(OVERSAMPLE - 1));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state    <= LANE_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
		end else begin
			unique case (state)
				LANE_IDLE: begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (bus.start)
						state <= LANE_START;
				end

				LANE_START: begin
					if (bus.start) begin
						tick_cnt <= '0;	// new edge after a short glitch, rearm
					end else if (half_end) begin
						tick_cnt <= '0;
						bit_cnt  <= '0;
						// line back high at mid-start means it was noise
						state    <= bus.line ? LANE_IDLE : LANE_DATA;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				LANE_DATA: begin
					if (bit_end) begin
						tick_cnt <= '0;
						if (bit_cnt == BIT_CNT_W'(DATA_BITS - 1))
							state <= LANE_STOP;
						else
							bit_cnt <= bit_cnt + 1'b1;
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				LANE_STOP: begin
					if (bit_end) begin
						tick_cnt <= '0;
						state    <= LANE_IDLE;	// free for the next edge mid stop bit
					end else if (tick) begin
						tick_cnt <= tick_cnt + 1'b1;
					end
				end

				default: state <= LANE_IDLE;
			endcase
		end
	end

	// lsb arrives first, so shift in from the top
	always_ff @(posedge clk) begin
		if (state == LANE_DATA && bit_end)
			shreg <= {bus.line, shreg[DATA_BITS-1:1]};
	end

	// done falls on the stop sample itself
	assign bus.done      = (state == LANE_STOP) && bit_end;
	assign bus.data      = shreg;
	assign bus.frame_err = ~bus.line;	// stop bit must be high

	// ticks from the front end are single-cycle and never back to back
	a_done_single: assert property (
		@(posedge clk) disable iff (!rst_n)
		bus.done |=> !bus.done
	) else $error("done held for more than one cycle");

endmodule : rx_lane

// ==== rx_collector.sv ====
`timescale 1ns/100ps

module rx_collector
	import uart_types_pkg::*;
#(
	parameter  int NUM_LANES = 4,
	localparam int CHAN_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic              clk,
	input  logic              rst_n,
	rx_lane_if.sink           lanes [NUM_LANES],
	output logic              out_valid,
	output rx_byte_t          out_data,
	output logic [CHAN_W-1:0] out_chan,
	output logic              out_frame_err
);

	logic        pending   [NUM_LANES];	// holding register full
	rx_byte_t    hold_data [NUM_LANES];
	logic        hold_err  [NUM_LANES];
	logic [CHAN_W-1:0] last;	// lane served most recently
	logic [CHAN_W-1:0] sel;
	logic              found;

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_hold
		always_ff @(posedge clk or negedge rst_n) begin
			if (!rst_n)
				pending[g] <= 1'b0;
			else if (lanes[g].done)
				pending[g] <= 1'b1;
			else if (found && sel == CHAN_W'(g))
				pending[g] <= 1'b0;	// drained this cycle
		end

		always_ff @(posedge clk) begin
			if (lanes[g].done) begin
				hold_data[g] <= lanes[g].data;
				hold_err[g]  <= lanes[g].frame_err;
			end
		end

		// a frame takes ten bit times, the drain at most NUM_LANES cycles
		a_no_overrun: assert property (
			@(posedge clk) disable iff (!rst_n)
			lanes[g].done |-> !pending[g]
		) else $error("lane %0d finished a byte before the last one left", g);
	end

	// round robin, search starts one past the last lane served
	always_comb begin
		int idx;
		sel   = '0;
		found = 1'b0;
		for (int k = 1; k <= NUM_LANES; k++) begin
			idx = (int'(last) + k) % NUM_LANES;
			if (!found && pending[idx]) begin
				found = 1'b1;
				sel   = CHAN_W'(idx);
			end
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			last      <= CHAN_W'(NUM_LANES - 1);	// lane 0 gets first turn
		end else begin
			out_valid <= found;
			if (found)
				last <= sel;
		end
	end

	always_ff @(posedge clk) begin
		if (found) begin
			out_data      <= hold_data[sel];
			out_chan      <= sel;
			out_frame_err <= hold_err[sel];
		end
	end

	a_chan_range: assert property (
		@(posedge clk) disable iff (!rst_n)
		out_valid |-> (int'(out_chan) < NUM_LANES)
	) else $error("out_chan %0d out of range", out_chan);

endmodule : rx_collector

// ==== multi_uart_rx.sv ====
`timescale 1ns/100ps

module multi_uart_rx
	import uart_types_pkg::*;
#(
	parameter  int CLK_FREQ  = 50_000_000,
	parameter  int BAUD      = 115_200,
	parameter  int NUM_LANES = 4,
	localparam int CHAN_W    = (NUM_LANES > 1) ? $clog2(NUM_LANES) : 1
) (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic [NUM_LANES-1:0] rx,	// one serial line per channel
	output logic                 out_valid,
	output rx_byte_t             out_data,
	output logic [CHAN_W-1:0]    out_chan,
	output logic                 out_frame_err
);

	logic tick;	// shared 16x sample strobe

	rx_lane_if lanes [NUM_LANES] ();

	rx_front #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD      (BAUD),
		.NUM_LANES (NUM_LANES)
	) i_front (
		.clk   (clk),
		.rst_n (rst_n),
		.rx    (rx),
		.tick  (tick),
		.lanes (lanes)
	);

	for (genvar g = 0; g < NUM_LANES; g++) begin : g_lane
		rx_lane i_lane (
			.clk   (clk),
			.rst_n (rst_n),
			.tick  (tick),
			.bus   (lanes[g])
		);
	end

	rx_collector #(
		.NUM_LANES (NUM_LANES)
	) i_collector (
		.clk           (clk),
		.rst_n         (rst_n),
		.lanes         (lanes),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_chan      (out_chan),
		.out_frame_err (out_frame_err)
	);

endmodule : multi_uart_rx

// ==== tb_multi_uart_rx.sv ====
`timescale 1ns/100ps

module tb_multi_uart_rx;

	localparam int CLK_FREQ    = 3_200_000;
	localparam int BAUD        = 100_000;
	localparam int NUM_LANES   = 4;
	localparam int CLK_NS      = 10;
	localparam int BIT_CLKS    = 32;	// 16 ticks of 2 clocks
	localparam int RAND_FRAMES = 40;
	localparam int MAX_GAP     = 64;	// random start offset, clocks
	localparam int EXP_DEPTH   = 64;
	localparam int FRAME_COUNT = 4 + 4 + 1 + 2 + RAND_FRAMES;
	localparam int WATCHDOG_NS =
		(FRAME_COUNT * 10 * BIT_CLKS + RAND_FRAMES * MAX_GAP + 10_000) * CLK_NS;

	logic                 clk;
	logic                 rst_n;
	logic [NUM_LANES-1:0] rx;
	logic                 out_valid;
	logic [7:0]           out_data;
	logic [1:0]           out_chan;
	logic                 out_frame_err;

	integer seed = 32'hf9f8;

	// expected entries per lane, {frame_err, data}
	logic [8:0] exp_mem [NUM_LANES][EXP_DEPTH];
	int         wr_cnt  [NUM_LANES];
	int         rd_cnt  [NUM_LANES];

	logic [7:0] rnd_data [RAND_FRAMES];
	int         rnd_lane [RAND_FRAMES];
	int         rnd_gap  [RAND_FRAMES];
	logic       rnd_stop [RAND_FRAMES];

	multi_uart_rx #(
		.CLK_FREQ  (CLK_FREQ),
		.BAUD      (BAUD),
		.NUM_LANES (NUM_LANES)
	) i_dut (
		.clk           (clk),
		.rst_n         (rst_n),
		.rx            (rx),
		.out_valid     (out_valid),
		.out_data      (out_data),
		.out_chan      (out_chan),
		.out_frame_err (out_frame_err)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_NS / 2) clk = ~clk;
	end

	// decode a frame as sent on the wire: bit 0 start, 8:1 data lsb first, 9 stop
	function automatic logic [8:0] expected_entry(input logic [9:0] frame);
		logic [7:0] data;
		logic       err;
		for (int b = 0; b < 8; b++)
			data[b] = frame[b + 1];
		err = (frame[9] == 1'b0);	// stop bit must be high
		return {err, data};
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		if (actual !== expected) begin
			$display("CHECK FAILED at %0t ns: %s is 0x%0h, expected 0x%0h",
				$time, name, actual, expected);
			$display("*** FAILED ***");
			$fatal(1, "value mismatch on %s", name);
		end
	endtask

	task automatic push_expected(input int lane, input logic [8:0] entry);
		exp_mem[lane][wr_cnt[lane] % EXP_DEPTH] = entry;
		wr_cnt[lane]++;
	endtask

	// call on a rising edge, returns on one
	task automatic send_frame(input int lane, input logic [7:0] data, input logic stop_bit);
		logic [9:0] frame;
		frame = {stop_bit, data, 1'b0};
		push_expected(lane, expected_entry(frame));
		for (int b = 0; b < 10; b++) begin
			rx[lane] <= frame[b];
			repeat (BIT_CLKS) @(posedge clk);
		end
		rx[lane] <= 1'b1;
		if (!stop_bit)
			repeat (BIT_CLKS) @(posedge clk);	// idle so the next start has an edge
	endtask

	// low for a quarter bit, the lane should reject it at mid-start
	task automatic send_glitch(input int lane);
		rx[lane] <= 1'b0;
		repeat (8) @(posedge clk);
		rx[lane] <= 1'b1;
		repeat (BIT_CLKS) @(posedge clk);	// still high at the mid-start sample
	endtask

	task automatic send_random_lane(input int lane);
		for (int i = 0; i < RAND_FRAMES; i++) begin
			if (rnd_lane[i] == lane) begin
				repeat (rnd_gap[i]) @(posedge clk);
				send_frame(lane, rnd_data[i], rnd_stop[i]);
			end
		end
	endtask

	function automatic int outstanding();
		int n;
		n = 0;
		for (int l = 0; l < NUM_LANES; l++)
			n += wr_cnt[l] - rd_cnt[l];
		return n;
	endfunction

	task automatic wait_drained();
		while (outstanding() != 0)
			@(posedge clk);
		repeat (BIT_CLKS) @(posedge clk);
	endtask

	// compare on the falling edge, outputs are registered on the rising one
	always @(negedge clk) begin
		logic [8:0] exp_entry;
		int         ch;
		if (rst_n && out_valid) begin
			if ($isunknown(out_chan)) begin
				$display("out_chan is unknown while out_valid is high at %0t ns", $time);
				$display("*** FAILED ***");
				$fatal(1, "unknown channel");
			end
			ch = out_chan;
			if (wr_cnt[ch] == rd_cnt[ch]) begin
				$display("byte 0x%0h came out on channel %0d at %0t ns, none was sent there",
					out_data, ch, $time);
				$display("*** FAILED ***");
				$fatal(1, "unexpected output");
			end
			exp_entry = exp_mem[ch][rd_cnt[ch] % EXP_DEPTH];
			rd_cnt[ch]++;
			check_value("out_data", out_data, exp_entry[7:0]);
			check_value("out_frame_err", out_frame_err, exp_entry[8]);
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired after %0d ns with %0d bytes outstanding",
			WATCHDOG_NS, outstanding());
		$display("*** FAILED ***");
		$fatal(1, "timeout");
	end

	initial begin
		int leftover;
		int total;
		rst_n = 1'b0;
		rx    = '1;	// lines idle high
		for (int l = 0; l < NUM_LANES; l++) begin
			wr_cnt[l] = 0;
			rd_cnt[l] = 0;
		end
		for (int i = 0; i < RAND_FRAMES; i++) begin
			rnd_lane[i] = $unsigned($random(seed)) % NUM_LANES;
			rnd_data[i] = 8'($random(seed));
			rnd_gap[i]  = $unsigned($random(seed)) % MAX_GAP;
			rnd_stop[i] = ($unsigned($random(seed)) % 8) != 0;	// some framing errors
		end
		repeat (8) @(posedge clk);
		rst_n <= 1'b1;

		// quiet lines give no output
		repeat (200) begin
			@(negedge clk);
			check_value("out_valid", out_valid, 1'b0);
		end
		@(posedge clk);

		// one byte per lane, in turn
		for (int l = 0; l < NUM_LANES; l++)
			send_frame(l, 8'($random(seed)), 1'b1);
		wait_drained();

		// all lanes at once
		fork
			send_frame(0, 8'h11, 1'b1);
			send_frame(1, 8'h22, 1'b1);
			send_frame(2, 8'h44, 1'b1);
			send_frame(3, 8'h88, 1'b1);
		join
		wait_drained();

		send_frame(2, 8'ha5, 1'b0);	// low stop bit
		wait_drained();

		send_glitch(1);
		send_frame(1, 8'h3c, 1'b1);
		wait_drained();

		fork
			send_random_lane(0);
			send_random_lane(1);
			send_random_lane(2);
			send_random_lane(3);
		join
		wait_drained();

		repeat (4 * BIT_CLKS) @(posedge clk);	// catch any late strays
		leftover = outstanding();
		total    = 0;
		for (int l = 0; l < NUM_LANES; l++)
			total += rd_cnt[l];
		if (leftover != 0) begin
			$display("%0d expected bytes never came out", leftover);
			$display("*** FAILED ***");
			$fatal(1, "missing output bytes");
		end else begin
			$display("%0d bytes received and checked", total);
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule : tb_multi_uart_rx

// ==== multi_uart_rx.f ====
uart_cfg_pkg.sv
uart_types_pkg.sv
rx_lane_if.sv
rx_front.sv
rx_lane.sv
rx_collector.sv
multi_uart_rx.sv
tb_multi_uart_rx.sv
